//--- logic/matmul_defines.svh
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

// Data and address widths
`define DWIDTH       8
`define AWIDTH       10
`define STRIDE_WIDTH 8

// Mesh is square, one PE per element of C
`define ARRAY_SIZE   4

// Pipeline depths of the MAC cell and of the A and B memories
`define MAC_STAGES   3
`define MEM_LATENCY  1

// Run schedule
`define CNT_WIDTH    8
// Last wavefront reaches PE(3,3) after 3*N-1 cycles, plus the MAC pipeline
`define CAPTURE_CNT  (3 * `ARRAY_SIZE - 1 + `MAC_STAGES)

`endif

//--- logic/matmul_pkg.sv
`include "matmul_defines.svh"

package matmul_pkg;

    // One matrix element
    typedef logic [`DWIDTH-1:0] elem_t;

    // One memory word: a column of A or a row of B, lane i in element i
    typedef elem_t [`ARRAY_SIZE-1:0] vec_t;

    // Memory address and address stride
    typedef logic [`AWIDTH-1:0] addr_t;
    typedef logic [`STRIDE_WIDTH-1:0] stride_t;

    // Cycle count within one run
    typedef logic [`CNT_WIDTH-1:0] cnt_t;

endpackage

//--- logic/processing_element.sv
`timescale 1ns/1ps

module processing_element
(
    input  logic              clk,
    input  logic              clear,
    input  matmul_pkg::elem_t in_a,
    input  matmul_pkg::elem_t in_b,
    output matmul_pkg::elem_t out_a,
    output matmul_pkg::elem_t out_b,
    output matmul_pkg::elem_t acc
);

    matmul_pkg::elem_t a_q;
    matmul_pkg::elem_t b_q;
    matmul_pkg::elem_t prod_q;
    matmul_pkg::elem_t acc_q;

    // Three stages: operand register, product register, accumulator.
    // Only the low byte of the product is kept, so the sum wraps mod 256.
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            a_q    <= '0;
            b_q    <= '0;
            prod_q <= '0;
            acc_q  <= '0;
        end
        else
        begin
            a_q    <= in_a;
            b_q    <= in_b;
            prod_q <= matmul_pkg::elem_t'(a_q * b_q);
            acc_q  <= acc_q + prod_q;
        end
    end

    // The operand registers double as the hop to the next PE
    assign out_a = a_q;
    assign out_b = b_q;
    assign acc   = acc_q;

endmodule

//--- logic/pe_array.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module pe_array
(
    input  logic             clk,
    input  logic             reset,
    input  logic             pe_reset,
    input  matmul_pkg::vec_t a_edge,
    input  matmul_pkg::vec_t b_edge,
    output matmul_pkg::vec_t c_cols [`ARRAY_SIZE]
);

    // a_link[r][c] feeds PE(r,c) from the left, b_link[r][c] from above.
    // The extra column and row catch the operands leaving the mesh.
    matmul_pkg::elem_t a_link [`ARRAY_SIZE][`ARRAY_SIZE+1];
    matmul_pkg::elem_t b_link [`ARRAY_SIZE+1][`ARRAY_SIZE];
    logic              pe_clear;

    // Accumulators start a fresh product only on pe_reset
    assign pe_clear = reset | pe_reset;

    genvar r;
    genvar c;
    generate
        for (r = 0; r < `ARRAY_SIZE; r++)
        begin : g_edge
            assign a_link[r][0] = a_edge[r];
            assign b_link[0][r] = b_edge[r];
        end

        //////////////////////////////////////////////////////////////////
        // Mesh, A moves right and B moves down one PE per cycle
        //////////////////////////////////////////////////////////////////

        for (r = 0; r < `ARRAY_SIZE; r++)
        begin : g_row
            for (c = 0; c < `ARRAY_SIZE; c++)
            begin : g_col
                processing_element u_pe
                (
                    .clk   (clk),
                    .clear (pe_clear),
                    .in_a  (a_link[r][c]),
                    .in_b  (b_link[r][c]),
                    .out_a (a_link[r][c+1]),
                    .out_b (b_link[r+1][c]),
                    .acc   (c_cols[c][r])
                );
            end
        end
    endgenerate

endmodule

//--- logic/operand_feeder.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module operand_feeder
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_mat_mul,
    input  matmul_pkg::cnt_t    clk_cnt,
    input  matmul_pkg::addr_t   base_addr,
    input  matmul_pkg::stride_t stride,
    input  matmul_pkg::vec_t    mem_data,
    output matmul_pkg::addr_t   mem_addr,
    output matmul_pkg::vec_t    skewed
);

    logic                    issue_q;
    logic [`MEM_LATENCY-1:0] valid_q;
    matmul_pkg::vec_t        masked;

    //////////////////////////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////////////////////////

    // One word per cycle for the first ARRAY_SIZE cycles of the run.
    // Outside the window the address rests on a word of the same set.
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            mem_addr <= base_addr;
            issue_q  <= 1'b0;
        end
        else if (clk_cnt < matmul_pkg::cnt_t'(`ARRAY_SIZE))
        begin
            if (clk_cnt == '0)
            begin
                mem_addr <= base_addr;
            end
            else
            begin
                mem_addr <= mem_addr + matmul_pkg::addr_t'(stride);
            end
            issue_q <= 1'b1;
        end
        else
        begin
            issue_q <= 1'b0;
        end
    end

    // Read data trails the address by the memory latency
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q[0] <= issue_q;
            for (int k = 1; k < `MEM_LATENCY; k++)
            begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    // Anything outside the read window enters the mesh as zero
    assign masked = valid_q[`MEM_LATENCY-1] ? mem_data : '0;

    //////////////////////////////////////////////////////////////////////
    // Systolic skew, lane i delayed by i cycles
    //////////////////////////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `ARRAY_SIZE; i++)
        begin : g_lane
            if (i == 0)
            begin : g_direct
                assign skewed[i] = masked[i];
            end
            else
            begin : g_delay
                matmul_pkg::elem_t chain [i];

                always_ff @(posedge clk)
                begin
                    if (reset || !start_mat_mul)
                    begin
                        for (int k = 0; k < i; k++)
                        begin
                            chain[k] <= '0;
                        end
                    end
                    else
                    begin
                        chain[0] <= masked[i];
                        for (int k = 1; k < i; k++)
                        begin
                            chain[k] <= chain[k-1];
                        end
                    end
                end

                assign skewed[i] = chain[i-1];
            end
        end
    endgenerate

endmodule

//--- logic/matmul_sequencer.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_sequencer
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start_mat_mul,
    output matmul_pkg::cnt_t clk_cnt,
    output logic             capture,
    output logic             done_mat_mul
);

    //////////////////////////////////////////////////////////////////////
    // Run cycle counter
    //////////////////////////////////////////////////////////////////////

    // Counts edges since start went high; saturates so a long-held
    // start cannot wrap around and fire a second capture or done
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            clk_cnt <= '0;
        end
        else if (clk_cnt != '1)
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // All accumulators hold their final sums in this cycle
    assign capture = (clk_cnt == matmul_pkg::cnt_t'(`CAPTURE_CNT));

    //////////////////////////////////////////////////////////////////////
    // Done pulse
    //////////////////////////////////////////////////////////////////////

    // Rises the cycle after the drain has shown its last column
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            done_mat_mul <= 1'b0;
        end
        else
        begin
            done_mat_mul <= (clk_cnt == matmul_pkg::cnt_t'(`CAPTURE_CNT + `ARRAY_SIZE));
        end
    end

endmodule

//--- logic/result_drain.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module result_drain
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_mat_mul,
    input  logic                capture,
    input  matmul_pkg::vec_t    c_cols [`ARRAY_SIZE],
    input  matmul_pkg::addr_t   address_mat_c,
    input  matmul_pkg::stride_t address_stride_c,
    output matmul_pkg::vec_t    c_data_out,
    output matmul_pkg::addr_t   c_addr,
    output logic                c_data_available
);

    // Columns still waiting to go out after the one on c_data_out
    matmul_pkg::vec_t            shift_q [`ARRAY_SIZE-1];
    logic [$clog2(`ARRAY_SIZE):0] col_cnt;

    //////////////////////////////////////////////////////////////////////
    // Capture and shift out
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            c_data_available <= 1'b0;
            c_data_out       <= '0;
            c_addr           <= '0;
            col_cnt          <= '0;
        end
        else if (capture)
        begin
            // Column 0 goes out at once, the rest wait in the shift register
            c_data_out       <= c_cols[0];
            c_addr           <= address_mat_c;
            c_data_available <= 1'b1;
            col_cnt          <= 1;
            for (int k = 0; k < `ARRAY_SIZE - 1; k++)
            begin
                shift_q[k] <= c_cols[k+1];
            end
        end
        else if (c_data_available)
        begin
            if (col_cnt == `ARRAY_SIZE)
            begin
                c_data_available <= 1'b0;
                c_data_out       <= '0;
            end
            else
            begin
                c_data_out <= shift_q[0];
                c_addr     <= c_addr + matmul_pkg::addr_t'(address_stride_c);
                col_cnt    <= col_cnt + 1'b1;
                for (int k = 0; k < `ARRAY_SIZE - 2; k++)
                begin
                    shift_q[k] <= shift_q[k+1];
                end
                shift_q[`ARRAY_SIZE-2] <= '0;
            end
        end
    end

endmodule

//--- logic/matmul_top.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                pe_reset,
    input  logic                start_mat_mul,
    input  matmul_pkg::addr_t   address_mat_a,
    input  matmul_pkg::addr_t   address_mat_b,
    input  matmul_pkg::addr_t   address_mat_c,
    input  matmul_pkg::stride_t address_stride_a,
    input  matmul_pkg::stride_t address_stride_b,
    input  matmul_pkg::stride_t address_stride_c,
    input  matmul_pkg::vec_t    a_data,
    input  matmul_pkg::vec_t    b_data,
    output matmul_pkg::addr_t   a_addr,
    output matmul_pkg::addr_t   b_addr,
    output matmul_pkg::addr_t   c_addr,
    output matmul_pkg::vec_t    c_data_out,
    output logic                c_data_available,
    output logic                done_mat_mul
);

    matmul_pkg::cnt_t clk_cnt;
    logic             capture;
    matmul_pkg::vec_t a_edge;
    matmul_pkg::vec_t b_edge;
    matmul_pkg::vec_t c_cols [`ARRAY_SIZE];

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    matmul_sequencer u_sequencer
    (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .capture       (capture),
        .done_mat_mul  (done_mat_mul)
    );

    //////////////////////////////////////////////////////////////////////
    // Operand fetch, A enters from the left and B from the top
    //////////////////////////////////////////////////////////////////////

    operand_feeder u_feed_a
    (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .base_addr     (address_mat_a),
        .stride        (address_stride_a),
        .mem_data      (a_data),
        .mem_addr      (a_addr),
        .skewed        (a_edge)
    );

    operand_feeder u_feed_b
    (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .base_addr     (address_mat_b),
        .stride        (address_stride_b),
        .mem_data      (b_data),
        .mem_addr      (b_addr),
        .skewed        (b_edge)
    );

    //////////////////////////////////////////////////////////////////////
    // Mesh and result output
    //////////////////////////////////////////////////////////////////////

    pe_array u_pe_array
    (
        .clk      (clk),
        .reset    (reset),
        .pe_reset (pe_reset),
        .a_edge   (a_edge),
        .b_edge   (b_edge),
        .c_cols   (c_cols)
    );

    result_drain u_result_drain
    (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .capture          (capture),
        .c_cols           (c_cols),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

//--- testbench/matmul_sva.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_sva
(
    input logic clk,
    input logic reset,
    input logic c_data_available,
    input logic done_mat_mul
);

    // Consecutive earlier edges that saw c_data_available high
    logic [$clog2(`ARRAY_SIZE)+1:0] avail_run;

    // Number of assertion failures so far
    int fail_count = 0;

    always_ff @(posedge clk)
    begin
        if (reset || !c_data_available)
        begin
            avail_run <= '0;
        end
        else if (avail_run != '1)
        begin
            avail_run <= avail_run + 1'b1;
        end
    end

    done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul)
        else
        begin
            $error("done_mat_mul stayed high for two consecutive cycles");
            fail_count++;
        end

    // A fifth high cycle in a row means the window ran too long
    avail_window_limit: assert property (@(posedge clk) disable iff (reset)
        !(c_data_available && avail_run == `ARRAY_SIZE))
        else
        begin
            $error("c_data_available stayed high for more than four cycles");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !c_data_available && !done_mat_mul)
        else
        begin
            $error("c_data_available or done_mat_mul high during reset");
            fail_count++;
        end

endmodule

bind matmul_top matmul_sva u_sva
(
    .clk              (clk),
    .reset            (reset),
    .c_data_available (c_data_available),
    .done_mat_mul     (done_mat_mul)
);

//--- testbench/matmul_tb.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_tb;

    localparam int wait_limit = 100;
    localparam int num_tests  = 5;
    localparam int mem_words  = 1 << `AWIDTH;

    typedef struct packed
    {
        matmul_pkg::addr_t   base_a;
        matmul_pkg::stride_t stride_a;
        matmul_pkg::addr_t   base_b;
        matmul_pkg::stride_t stride_b;
        matmul_pkg::addr_t   base_c;
        matmul_pkg::stride_t stride_c;
        logic                clear_pe;
        logic                ident_a;
    } test_row_t;

    // base_a, stride_a, base_b, stride_b, base_c, stride_c, pe_reset, identity A
    localparam test_row_t test_table [num_tests] = '{
        '{10'h000, 8'd1,   10'h000, 8'd1,   10'h000, 8'd1,   1'b1, 1'b1},
        '{10'h010, 8'd1,   10'h020, 8'd1,   10'h100, 8'd1,   1'b1, 1'b0},
        '{10'h123, 8'd7,   10'h3f0, 8'd9,   10'h2a0, 8'd33,  1'b1, 1'b0},
        '{10'h040, 8'd3,   10'h080, 8'd5,   10'h3f8, 8'd4,   1'b0, 1'b0},
        '{10'h005, 8'd255, 10'h002, 8'd128, 10'h000, 8'd255, 1'b1, 1'b0}
    };

    string test_names [num_tests] = '{"identity", "random product", "strided addressing",
                                      "accumulation", "wide strides"};

    logic                clk;
    logic                reset;
    logic                pe_reset;
    logic                start_mat_mul;
    matmul_pkg::addr_t   address_mat_a;
    matmul_pkg::addr_t   address_mat_b;
    matmul_pkg::addr_t   address_mat_c;
    matmul_pkg::stride_t address_stride_a;
    matmul_pkg::stride_t address_stride_b;
    matmul_pkg::stride_t address_stride_c;
    matmul_pkg::vec_t    a_data;
    matmul_pkg::vec_t    b_data;
    matmul_pkg::addr_t   a_addr;
    matmul_pkg::addr_t   b_addr;
    matmul_pkg::addr_t   c_addr;
    matmul_pkg::vec_t    c_data_out;
    logic                c_data_available;
    logic                done_mat_mul;

    matmul_pkg::vec_t  mem_a [mem_words];
    matmul_pkg::vec_t  mem_b [mem_words];
    matmul_pkg::elem_t a_mat [`ARRAY_SIZE][`ARRAY_SIZE];
    matmul_pkg::elem_t b_mat [`ARRAY_SIZE][`ARRAY_SIZE];
    matmul_pkg::elem_t c_ref [`ARRAY_SIZE][`ARRAY_SIZE];
    test_row_t         cur;
    int unsigned       lcg_state = 52854;
    int                errors;
    int                bad_reads;
    int                tests_passed;
    int                tests_failed;
    bit                timed_out;

    matmul_top uut
    (
        .clk              (clk),
        .reset            (reset),
        .pe_reset         (pe_reset),
        .start_mat_mul    (start_mat_mul),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_mat_c    (address_mat_c),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .address_stride_c (address_stride_c),
        .a_data           (a_data),
        .b_data           (b_data),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available),
        .done_mat_mul     (done_mat_mul)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic matmul_pkg::elem_t rand_elem();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return matmul_pkg::elem_t'(lcg_state >> 16);
    endfunction

    // Background content, so a stray read returns something recognisable
    function automatic matmul_pkg::vec_t fill_word(int addr, int salt);
        matmul_pkg::vec_t w;
        for (int i = 0; i < `ARRAY_SIZE; i++)
        begin
            w[i] = matmul_pkg::elem_t'(addr * (2 * i + 3) + (addr >> 8) * 37 + salt);
        end
        return w;
    endfunction

    // Word k of a strided matrix, wrapping at the top of the address space
    function automatic matmul_pkg::addr_t step_addr(matmul_pkg::addr_t base,
                                                    matmul_pkg::stride_t stride, int k);
        return matmul_pkg::addr_t'(int'(base) + k * int'(stride));
    endfunction

    function automatic bit in_read_set(matmul_pkg::addr_t addr, matmul_pkg::addr_t base,
                                       matmul_pkg::stride_t stride);
        for (int k = 0; k < `ARRAY_SIZE; k++)
        begin
            if (addr == step_addr(base, stride, k))
            begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Wrong values, stray reads and assertion failures seen so far
    function automatic int total_faults();
        return errors + bad_reads + uut.u_sva.fail_count;
    endfunction

    task automatic check_vec(string what, matmul_pkg::vec_t got, matmul_pkg::vec_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(string what, matmul_pkg::addr_t got, matmul_pkg::addr_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory models, one cycle read latency
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
        if (start_mat_mul && !in_read_set(a_addr, cur.base_a, cur.stride_a))
        begin
            $display("Matrix A memory was read at %h, which holds no word of A", a_addr);
            bad_reads++;
        end
        if (start_mat_mul && !in_read_set(b_addr, cur.base_b, cur.stride_b))
        begin
            $display("Matrix B memory was read at %h, which holds no word of B", b_addr);
            bad_reads++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operands and reference model
    //////////////////////////////////////////////////////////////////////

    // A goes to memory as columns (lane i = row i), B as rows (lane j = column j)
    task automatic load_operands();
        matmul_pkg::vec_t word;
        for (int k = 0; k < `ARRAY_SIZE; k++)
        begin
            for (int i = 0; i < `ARRAY_SIZE; i++)
            begin
                if (cur.ident_a)
                begin
                    a_mat[i][k] = (i == k) ? 8'd1 : 8'd0;
                end
                else
                begin
                    a_mat[i][k] = rand_elem();
                end
                b_mat[k][i] = rand_elem();
            end
        end
        for (int k = 0; k < `ARRAY_SIZE; k++)
        begin
            for (int i = 0; i < `ARRAY_SIZE; i++)
            begin
                word[i] = a_mat[i][k];
            end
            mem_a[step_addr(cur.base_a, cur.stride_a, k)] = word;
            for (int j = 0; j < `ARRAY_SIZE; j++)
            begin
                word[j] = b_mat[k][j];
            end
            mem_b[step_addr(cur.base_b, cur.stride_b, k)] = word;
        end
    endtask

    // C = A x B mod 256, added onto the old C when the PEs are not cleared
    task automatic compute_expected();
        int sum;
        for (int i = 0; i < `ARRAY_SIZE; i++)
        begin
            for (int j = 0; j < `ARRAY_SIZE; j++)
            begin
                sum = cur.clear_pe ? 0 : int'(c_ref[i][j]);
                for (int k = 0; k < `ARRAY_SIZE; k++)
                begin
                    sum += int'(a_mat[i][k]) * int'(b_mat[k][j]);
                end
                c_ref[i][j] = matmul_pkg::elem_t'(sum);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Waits and test sequence
    //////////////////////////////////////////////////////////////////////

    task automatic wait_for_available();
        int n;
        n = 0;
        while (!c_data_available && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!c_data_available)
        begin
            $display("Gave up after %0d cycles waiting for c_data_available", wait_limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (!done_mat_mul && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!done_mat_mul)
        begin
            $display("Gave up after %0d cycles waiting for done_mat_mul", wait_limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(int t);
        int               faults_before;
        matmul_pkg::vec_t exp_col;
        faults_before = total_faults();
        @(negedge clk);
        cur              = test_table[t];
        address_mat_a    = cur.base_a;
        address_mat_b    = cur.base_b;
        address_mat_c    = cur.base_c;
        address_stride_a = cur.stride_a;
        address_stride_b = cur.stride_b;
        address_stride_c = cur.stride_c;
        load_operands();
        compute_expected();
        pe_reset = cur.clear_pe;
        @(negedge clk);
        pe_reset = 1'b0;
        // One idle edge lets the feeders load the new bases
        @(negedge clk);
        start_mat_mul = 1'b1;
        wait_for_available();
        if (!timed_out)
        begin
            for (int j = 0; j < `ARRAY_SIZE; j++)
            begin
                for (int i = 0; i < `ARRAY_SIZE; i++)
                begin
                    exp_col[i] = c_ref[i][j];
                end
                if (j > 0)
                begin
                    check_bit($sformatf("c_data_available at column %0d", j),
                              c_data_available, 1'b1);
                end
                check_bit($sformatf("done_mat_mul at column %0d", j), done_mat_mul, 1'b0);
                check_vec($sformatf("c_data_out column %0d", j), c_data_out, exp_col);
                check_addr($sformatf("c_addr column %0d", j), c_addr,
                           step_addr(cur.base_c, cur.stride_c, j));
                @(negedge clk);
            end
            check_bit("c_data_available after the last column", c_data_available, 1'b0);
            wait_for_done();
        end
        if (!timed_out)
        begin
            @(negedge clk);
            check_bit("done_mat_mul one cycle after its pulse", done_mat_mul, 1'b0);
            start_mat_mul = 1'b0;
        end
        if (!timed_out && total_faults() == faults_before)
        begin
            tests_passed++;
            $display("test %0d %s: PASS", t, test_names[t]);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: FAIL", t, test_names[t]);
        end
    endtask

    initial
    begin
        reset            = 1'b1;
        pe_reset         = 1'b0;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        a_data           = '0;
        b_data           = '0;
        cur              = test_table[0];
        errors           = 0;
        bad_reads        = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        timed_out        = 1'b0;
        for (int a = 0; a < mem_words; a++)
        begin
            mem_a[a] = fill_word(a, 8'h11);
            mem_b[a] = fill_word(a, 8'h7c);
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_bit("done_mat_mul after reset", done_mat_mul, 1'b0);
        check_bit("c_data_available after reset", c_data_available, 1'b0);
        check_vec("c_data_out after reset", c_data_out, '0);
        for (int t = 0; t < num_tests && !timed_out; t++)
        begin
            run_test(t);
        end
        $display("summary: %0d of %0d passed, %0d errors, %0d stray reads, %0d assertion errors",
                 tests_passed, tests_passed + tests_failed, errors, bad_reads,
                 uut.u_sva.fail_count);
        if (tests_failed == 0 && total_faults() == 0 && !timed_out)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/matmul_pkg.sv
logic/processing_element.sv
logic/pe_array.sv
logic/operand_feeder.sv
logic/matmul_sequencer.sv
logic/result_drain.sv
logic/matmul_top.sv
testbench/matmul_sva.sv
testbench/matmul_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module matmul_tb --Mdir obj_dir -o matmul_sim
	@out="$$(./obj_dir/matmul_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
